// ==== rtl/dodge_pkg.sv ====
package dodge_pkg;

	//////////////////////////////
	// matrix geometry

	localparam int GRID = 8;

	typedef logic [GRID-1:0] row_t;    // active low, bit c is column c
	typedef logic [2:0] idx_t;
	typedef logic [3:0] height_t;      // 0..7 or EMPTY
	typedef height_t [GRID-1:0] field_t;
	typedef row_t [GRID-1:0] picture_t;

	typedef enum logic [1:0]
	{
		PLAYING,
		WON,
		LOST
	} state_t;

	localparam height_t EMPTY = 4'd8;    // column has no obstacle

	//////////////////////////////
	// game rules and timing

	localparam int LIFE_MAX      = 6;
	localparam int LIGHT_HIGH    = 4;
	localparam int LIGHT_MID     = 2;
	localparam int SURVIVE_STEPS = 40;
	localparam int STEP_DIV      = 96;    // clocks per game step
	localparam int SCAN_DIV      = 2;     // clocks per scanned row

	localparam logic [7:0] LFSR_SEED = 8'hA5;

	localparam int LIFE_W = $clog2(LIFE_MAX + 1);
	localparam int STEP_W = $clog2(SURVIVE_STEPS + 1);

	typedef logic [LIFE_W-1:0] life_t;
	typedef logic [STEP_W-1:0] steps_t;

	//////////////////////////////
	// end pictures from row 7 down

	localparam picture_t WIN_PIC =
	{
		8'b11000011,
		8'b10111101,
		8'b01111110,
		8'b01111110,
		8'b01111110,
		8'b01111110,
		8'b10111101,
		8'b11000011
	};

	localparam picture_t LOSE_PIC =
	{
		8'b01111110,
		8'b10111101,
		8'b11011011,
		8'b11100111,
		8'b11100111,
		8'b11011011,
		8'b10111101,
		8'b01111110
	};

endpackage

// ==== rtl/frame_write_if.sv ====
`timescale 1ns/1ps

// row writes from the renderer into the back bank
interface frame_write_if;

	logic               wr_en;
	dodge_pkg::idx_t    wr_row;
	dodge_pkg::row_t    wr_red;
	dodge_pkg::row_t    wr_blue;
	logic               commit;    // back bank complete

	modport producer
	(
		output wr_en,
		output wr_row,
		output wr_red,
		output wr_blue,
		output commit
	);

	modport store
	(
		input wr_en,
		input wr_row,
		input wr_red,
		input wr_blue,
		input commit
	);

endinterface

// ==== rtl/scan_read_if.sv ====
`timescale 1ns/1ps

// front bank read port for the row scanner
interface scan_read_if;

	dodge_pkg::idx_t    rd_row;
	dodge_pkg::row_t    red;
	dodge_pkg::row_t    blue;
	logic               frame_start;    // rd_row wraps to 0 after this cycle

	modport scanner
	(
		output rd_row,
		output frame_start,
		input  red,
		input  blue
	);

	modport store
	(
		input  rd_row,
		input  frame_start,
		output red,
		output blue
	);

endinterface

// ==== rtl/tick_divider.sv ====
`timescale 1ns/1ps

module tick_divider
#(
	parameter int DIVIDE = 2
)
(
	input  logic CLK,
	input  logic reset,
	output logic tick
);

	logic [$clog2(DIVIDE)-1:0] count;

	assign tick = (count == DIVIDE - 1);    // one clock wide

	always_ff @(posedge CLK)
	begin
		if (reset)
			count <= '0;
		else if (tick)
			count <= '0;
		else
			count <= count + 1'b1;
	end

endmodule

// ==== rtl/obstacle_field.sv ====
`timescale 1ns/1ps

module obstacle_field
(
	input  logic              CLK,
	input  logic              reset,
	input  logic              step,
	input  logic              clear_en,
	input  dodge_pkg::idx_t   clear_col,
	output dodge_pkg::field_t field
);

	logic [7:0]        lfsr;
	logic [7:0]        lfsr_next;
	dodge_pkg::idx_t   spawn_col;
	dodge_pkg::field_t advanced;

	// x^8 + x^6 + x^5 + x^4 + 1
	assign lfsr_next = {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
	assign spawn_col = lfsr_next[2:0];

	//////////////////////////////
	// fall by one row, then spawn

	always_comb
	begin
		for (int c = 0; c < dodge_pkg::GRID; c++)
		begin
			if (field[c] == dodge_pkg::EMPTY)
				advanced[c] = dodge_pkg::EMPTY;
			else if (field[c] == dodge_pkg::height_t'(dodge_pkg::GRID - 1))
				advanced[c] = dodge_pkg::EMPTY;    // drops off the bottom
			else
				advanced[c] = field[c] + 1'b1;
		end

		// one obstacle per column at most
		if (lfsr_next[7] && advanced[spawn_col] == dodge_pkg::EMPTY)
			advanced[spawn_col] = 4'd0;
	end

	//////////////////////////////
	// field and spawner state

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			field <= {dodge_pkg::GRID{dodge_pkg::EMPTY}};
			lfsr  <= dodge_pkg::LFSR_SEED;
		end
		else
		begin
			if (step)
			begin
				field <= advanced;
				lfsr  <= lfsr_next;
			end

			if (clear_en)
				field[clear_col] <= dodge_pkg::EMPTY;    // obstacle hit the player
		end
	end

endmodule

// ==== rtl/game_status.sv ====
`timescale 1ns/1ps

module game_status
(
	input  logic              CLK,
	input  logic              reset,
	input  logic              step,
	input  logic              left,
	input  logic              right,
	input  dodge_pkg::field_t field,
	output logic              clear_en,
	output dodge_pkg::idx_t   clear_col,
	output logic [2:0]        light,
	frame_write_if.producer   fw
);

	logic                step_d;
	logic                hit;
	dodge_pkg::state_t   state;
	dodge_pkg::idx_t     pos;
	dodge_pkg::life_t    life;
	dodge_pkg::steps_t   steps;
	logic                render_busy;
	logic [3:0]          render_cnt;
	dodge_pkg::row_t     obst_row;

	assign hit = (field[pos] == dodge_pkg::height_t'(dodge_pkg::GRID - 1));

	//////////////////////////////
	// evaluate one clock after a step

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			step_d   <= 1'b0;
			state    <= dodge_pkg::PLAYING;
			pos      <= '0;
			life     <= dodge_pkg::life_t'(dodge_pkg::LIFE_MAX);
			steps    <= '0;
			clear_en <= 1'b0;
		end
		else
		begin
			step_d   <= step;
			clear_en <= 1'b0;
			if (step_d && state == dodge_pkg::PLAYING)
			begin
				if (left)
				begin
					if (pos != '0)
						pos <= pos - 1'b1;
				end
				else if (right)
				begin
					if (pos != dodge_pkg::idx_t'(dodge_pkg::GRID - 1))
						pos <= pos + 1'b1;
				end

				steps <= steps + 1'b1;
				if (hit)
				begin
					life     <= life - 1'b1;
					clear_en <= 1'b1;
				end

				if (hit && life == dodge_pkg::life_t'(1))
					state <= dodge_pkg::LOST;
				else if (steps == dodge_pkg::steps_t'(dodge_pkg::SURVIVE_STEPS - 1))
					state <= dodge_pkg::WON;
			end
		end
	end

	always_ff @(posedge CLK)
	begin
		if (step_d)
			clear_col <= pos;    // column before the move
	end

	//////////////////////////////
	// eight row writes, then commit

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			render_busy <= 1'b0;
			render_cnt  <= '0;
		end
		else if (step_d)
		begin
			render_busy <= 1'b1;
			render_cnt  <= '0;
		end
		else if (render_busy)
		begin
			if (render_cnt[3])
				render_busy <= 1'b0;
			else
				render_cnt <= render_cnt + 1'b1;
		end
	end

	assign fw.wr_en  = render_busy && !render_cnt[3];
	assign fw.commit = render_busy && render_cnt[3];
	assign fw.wr_row = render_cnt[2:0];

	always_comb
	begin
		for (int c = 0; c < dodge_pkg::GRID; c++)
			obst_row[c] = (field[c] != dodge_pkg::height_t'(fw.wr_row));

		case (state)
			dodge_pkg::WON:
			begin
				fw.wr_red  = dodge_pkg::WIN_PIC[fw.wr_row];
				fw.wr_blue = dodge_pkg::WIN_PIC[fw.wr_row];
			end
			dodge_pkg::LOST:
			begin
				fw.wr_red  = dodge_pkg::LOSE_PIC[fw.wr_row];
				fw.wr_blue = '1;
			end
			default:
			begin
				fw.wr_red = obst_row;
				if (fw.wr_row == dodge_pkg::idx_t'(dodge_pkg::GRID - 1))
					fw.wr_blue = ~(dodge_pkg::row_t'(1) << pos);    // player
				else
					fw.wr_blue = '1;
			end
		endcase
	end

	// life lamps
	always_comb
	begin
		if (life >= dodge_pkg::LIGHT_HIGH)
			light = 3'b111;
		else if (life >= dodge_pkg::LIGHT_MID)
			light = 3'b011;
		else if (life != '0)
			light = 3'b001;
		else
			light = 3'b000;
	end

endmodule

// ==== rtl/frame_store.sv ====
`timescale 1ns/1ps

module frame_store
(
	input  logic          CLK,
	input  logic          reset,
	frame_write_if.store  fw,
	scan_read_if.store    sr
);

	logic              front;      // bank being scanned
	logic              pending;    // back bank holds a finished frame
	logic              swap;
	dodge_pkg::row_t   red_bank  [2][dodge_pkg::GRID];
	dodge_pkg::row_t   blue_bank [2][dodge_pkg::GRID];

	// a commit in the frame_start cycle swaps at once
	assign swap = sr.frame_start && (pending || fw.commit);

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			front   <= 1'b0;
			pending <= 1'b0;
			for (int b = 0; b < 2; b++)
			begin
				for (int r = 0; r < dodge_pkg::GRID; r++)
				begin
					red_bank[b][r]  <= '1;
					blue_bank[b][r] <= '1;
				end
			end
		end
		else
		begin
			if (fw.wr_en)
			begin
				red_bank[~front][fw.wr_row]  <= fw.wr_red;
				blue_bank[~front][fw.wr_row] <= fw.wr_blue;
			end

			if (swap)
			begin
				front   <= ~front;
				pending <= 1'b0;
			end
			else if (fw.commit)
				pending <= 1'b1;    // latest commit wins
		end
	end

	assign sr.red  = red_bank[front][sr.rd_row];
	assign sr.blue = blue_bank[front][sr.rd_row];

endmodule

// ==== rtl/matrix_scan.sv ====
`timescale 1ns/1ps

module matrix_scan
(
	input  logic             CLK,
	input  logic             reset,
	scan_read_if.scanner     sr,
	output logic [3:0]       COMM,
	output dodge_pkg::row_t  DATA_R,
	output dodge_pkg::row_t  DATA_B
);

	logic              row_tick;
	dodge_pkg::idx_t   row;

	tick_divider #(.DIVIDE(dodge_pkg::SCAN_DIV)) u_prescale
	(
		.CLK   (CLK),
		.reset (reset),
		.tick  (row_tick)
	);

	assign sr.rd_row      = row;
	assign sr.frame_start = row_tick && (row == dodge_pkg::idx_t'(dodge_pkg::GRID - 1));

	always_ff @(posedge CLK)
	begin
		if (reset)
			row <= '0;
		else if (row_tick)
			row <= row + 1'b1;    // wraps 7 -> 0
	end

	// select and data leave together
	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			COMM   <= 4'b1000;
			DATA_R <= '1;
			DATA_B <= '1;
		end
		else
		begin
			COMM   <= {1'b1, row};
			DATA_R <= sr.red;
			DATA_B <= sr.blue;
		end
	end

endmodule

// ==== rtl/dodge_top.sv ====
`timescale 1ns/1ps

module dodge_top
(
	input  logic             CLK,
	input  logic             reset,
	input  logic             left,
	input  logic             right,
	output dodge_pkg::row_t  DATA_R,
	output dodge_pkg::row_t  DATA_B,
	output logic [3:0]       COMM,
	output logic [2:0]       light
);

	logic                step;
	logic                clear_en;
	dodge_pkg::idx_t     clear_col;
	dodge_pkg::field_t   field;

	frame_write_if fw_bus ();
	scan_read_if   sr_bus ();

	//////////////////////////////
	// game side

	tick_divider #(.DIVIDE(dodge_pkg::STEP_DIV)) u_step_div
	(
		.CLK   (CLK),
		.reset (reset),
		.tick  (step)
	);

	obstacle_field u_field
	(
		.CLK       (CLK),
		.reset     (reset),
		.step      (step),
		.clear_en  (clear_en),
		.clear_col (clear_col),
		.field     (field)
	);

	game_status u_status
	(
		.CLK       (CLK),
		.reset     (reset),
		.step      (step),
		.left      (left),
		.right     (right),
		.field     (field),
		.clear_en  (clear_en),
		.clear_col (clear_col),
		.light     (light),
		.fw        (fw_bus.producer)
	);

	//////////////////////////////
	// display side

	frame_store u_store
	(
		.CLK   (CLK),
		.reset (reset),
		.fw    (fw_bus.store),
		.sr    (sr_bus.store)
	);

	matrix_scan u_scan
	(
		.CLK    (CLK),
		.reset  (reset),
		.sr     (sr_bus.scanner),
		.COMM   (COMM),
		.DATA_R (DATA_R),
		.DATA_B (DATA_B)
	);

endmodule

// ==== tb/tb_dodge.sv ====
`timescale 1ns/1ps

module tb_dodge;

	localparam int STEP      = dodge_pkg::STEP_DIV;
	localparam int SAMPLE_AT = 88;    // offset in a step where the new frame is on display
	localparam int WATCHDOG  = (dodge_pkg::SURVIVE_STEPS + 4) * dodge_pkg::STEP_DIV * 4;

	logic              CLK;
	logic              reset;
	logic              left;
	logic              right;
	dodge_pkg::row_t   DATA_R;
	dodge_pkg::row_t   DATA_B;
	logic [3:0]        COMM;
	logic [2:0]        light;

	int                cyc;
	int                errors;
	int                start_errors;
	int                tests_run;
	int                tests_failed;
	string             test_name;

	dodge_pkg::row_t   cap_red  [8];
	dodge_pkg::row_t   cap_blue [8];
	dodge_pkg::row_t   frm_red  [8];
	dodge_pkg::row_t   frm_blue [8];
	dodge_pkg::row_t   cur_red  [8];
	dodge_pkg::row_t   cur_blue [8];
	dodge_pkg::row_t   prev_red [8];
	logic [2:0]        last_row;
	int                hold;
	logic              scan_started;
	logic              first_change;

	// reference model
	int                m_pos;
	int                m_life;
	int                m_steps;
	dodge_pkg::state_t m_state;

	dodge_top dut
	(
		.CLK    (CLK),
		.reset  (reset),
		.left   (left),
		.right  (right),
		.DATA_R (DATA_R),
		.DATA_B (DATA_B),
		.COMM   (COMM),
		.light  (light)
	);

	initial CLK = 1'b0;
	always #2 CLK = ~CLK;

	always @(posedge CLK)
	begin
		if (reset)
			cyc <= 0;
		else
			cyc <= cyc + 1;
	end

	assert property (@(posedge CLK) disable iff (reset) COMM[3] == 1'b1)
	else
	begin
		$display("** Error: %s COMM select bit expected 1 actual 0", test_name);
		errors++;
	end

	task automatic check_value(string what, int exp, int act);
		assert (exp == act)
		else
		begin
			$display("** Error: %s %s expected %0h actual %0h", test_name, what, exp, act);
			errors++;
		end
	endtask

	function automatic int height_of(dodge_pkg::row_t rows [8], int c);
		int h;
		h = 8;
		for (int r = 7; r >= 0; r--)
			if (!rows[r][c])
				h = r;
		return h;
	endfunction

	function automatic int lamps_for(int life);
		if (life >= dodge_pkg::LIGHT_HIGH)
			return 7;
		else if (life >= dodge_pkg::LIGHT_MID)
			return 3;
		else if (life > 0)
			return 1;
		return 0;
	endfunction

	//////////////////////////////
	// frame capture and scan order

	always @(negedge CLK)
	begin
		if (reset)
		begin
			scan_started = 1'b0;
			first_change = 1'b1;
			hold = 0;
		end
		else
		begin
			if (!scan_started)
			begin
				scan_started = 1'b1;
				last_row = COMM[2:0];
				hold = 1;
			end
			else if (COMM[2:0] == last_row)
				hold++;
			else
			begin
				check_value("scan row", int'(3'(last_row + 3'd1)), int'(COMM[2:0]));
				if (!first_change)
					check_value("row hold cycles", dodge_pkg::SCAN_DIV, hold);
				first_change = 1'b0;
				if (last_row == 3'd7)
				begin
					frm_red  = cap_red;    // complete frame
					frm_blue = cap_blue;
				end
				last_row = COMM[2:0];
				hold = 1;
			end
			cap_red[COMM[2:0]]  = DATA_R;
			cap_blue[COMM[2:0]] = DATA_B;
		end
	end

	task automatic wait_cycle(int target);
		do
			@(posedge CLK);
		while (cyc < target);
		cur_red  = frm_red;    // stable at the rising edge
		cur_blue = frm_blue;
	endtask

	task automatic reset_dut();
		@(negedge CLK);
		reset = 1'b1;
		left  = 1'b0;
		right = 1'b0;
		repeat (8) @(negedge CLK);
		reset = 1'b0;
		check_value("COMM after reset", 8, int'(COMM));
		check_value("light after reset", 7, int'(light));
		check_value("DATA_R after reset", 8'hFF, int'(DATA_R));
		check_value("DATA_B after reset", 8'hFF, int'(DATA_B));
		wait_cycle(SAMPLE_AT);
		for (int r = 0; r < 8; r++)
		begin
			check_value($sformatf("idle red row %0d", r), 8'hFF, int'(cur_red[r]));
			check_value($sformatf("idle blue row %0d", r), 8'hFF, int'(cur_blue[r]));
		end
		prev_red = cur_red;
	endtask

	//////////////////////////////
	// reference model of one step

	task automatic model_step();
		logic                hit;
		int                  hit_col;
		int                  ph;
		int                  nh;
		int                  exp_h;
		int                  cnt;
		logic                ok;
		dodge_pkg::row_t     exp_b;
		if (m_state == dodge_pkg::PLAYING)
		begin
			hit     = !prev_red[6][m_pos];    // lands on the old column
			hit_col = m_pos;
			if (left)
			begin
				if (m_pos != 0)
					m_pos--;
			end
			else if (right)
			begin
				if (m_pos != 7)
					m_pos++;
			end
			m_steps++;
			if (hit)
				m_life--;
			if (hit && m_life == 0)
				m_state = dodge_pkg::LOST;
			else if (m_steps == dodge_pkg::SURVIVE_STEPS)
				m_state = dodge_pkg::WON;

			if (m_state == dodge_pkg::PLAYING)
			begin
				for (int c = 0; c < 8; c++)
				begin
					cnt = 0;
					for (int r = 0; r < 8; r++)
						if (!cur_red[r][c])
							cnt++;
					assert (cnt <= 1)
					else
					begin
						$display("** Error: %s column %0d expected at most 1 red pixel actual %0d",
							test_name, c, cnt);
						errors++;
					end
					ph = height_of(prev_red, c);
					nh = height_of(cur_red, c);
					if (ph >= 7 || (ph == 6 && hit && c == hit_col))
						exp_h = 8;    // leaves the field
					else
						exp_h = ph + 1;
					ok = (nh == exp_h) || (ph >= 7 && nh == 0);    // free column may spawn
					assert (ok)
					else
					begin
						$display("** Error: %s fall in column %0d expected %0d actual %0d",
							test_name, c, exp_h, nh);
						errors++;
					end
				end
			end
		end

		for (int r = 0; r < 8; r++)
		begin
			case (m_state)
				dodge_pkg::WON:
				begin
					check_value($sformatf("win red row %0d", r),
						int'(dodge_pkg::WIN_PIC[r]), int'(cur_red[r]));
					check_value($sformatf("win blue row %0d", r),
						int'(dodge_pkg::WIN_PIC[r]), int'(cur_blue[r]));
				end
				dodge_pkg::LOST:
				begin
					check_value($sformatf("lose red row %0d", r),
						int'(dodge_pkg::LOSE_PIC[r]), int'(cur_red[r]));
					check_value($sformatf("lose blue row %0d", r), 8'hFF, int'(cur_blue[r]));
				end
				default:
				begin
					exp_b = '1;
					if (r == 7)
						exp_b[m_pos] = 1'b0;    // player
					check_value($sformatf("blue row %0d", r), int'(exp_b), int'(cur_blue[r]));
				end
			endcase
		end
		check_value("light", lamps_for(m_life), int'(light));
	endtask

	//////////////////////////////
	// stimulus

	task automatic choose_inputs(int mode, int k);
		int best;
		int best_r;
		int h;
		int dest;
		int cand [4];
		if (mode == 0 && k <= 2)
		begin
			left  = 1'b1;
			right = 1'b0;
		end
		else if (mode == 0 && k <= 11)
		begin
			left  = 1'b0;
			right = 1'b1;
		end
		else if (mode == 0)
		begin
			// steer away from obstacles at row 5
			cand[0] = int'($urandom % 3) - 1;
			cand[1] = 0;
			cand[2] = -1;
			cand[3] = 1;
			dest = m_pos;
			for (int i = 3; i >= 0; i--)
				if (m_pos + cand[i] >= 0 && m_pos + cand[i] <= 7 && cur_red[5][m_pos + cand[i]])
					dest = m_pos + cand[i];
			left  = (dest < m_pos);
			right = (dest > m_pos) || (dest == m_pos && m_pos == 7 && $urandom % 2 == 0);
		end
		else
		begin
			best   = -1;
			best_r = -1;
			for (int c = 0; c < 8; c++)
			begin
				h = height_of(cur_red, c);
				if (h <= 5 && h > best_r && (c > m_pos ? c - m_pos : m_pos - c) <= 6 - h)
				begin
					best   = c;
					best_r = h;
				end
			end
			if (best < 0)
			begin
				left  = 1'($urandom % 2);
				right = 1'($urandom % 2);
			end
			else
			begin
				left  = (best < m_pos);
				right = (best > m_pos);
			end
		end
	endtask

	task automatic play(int mode, int n);
		reset_dut();
		m_pos   = 0;
		m_life  = dodge_pkg::LIFE_MAX;
		m_steps = 0;
		m_state = dodge_pkg::PLAYING;
		@(negedge CLK);
		choose_inputs(mode, 1);
		for (int k = 1; k <= n; k++)
		begin
			wait_cycle(k * STEP + SAMPLE_AT);
			@(negedge CLK);
			model_step();
			prev_red = cur_red;
			choose_inputs(mode, k + 1);
		end
	endtask

	task automatic start_test(string name);
		test_name    = name;
		start_errors = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors > start_errors)
		begin
			tests_failed++;
			$display("test %s: FAIL (%0d errors)", test_name, errors - start_errors);
		end
		else
			$display("test %s: PASS", test_name);
	endtask

	initial
	begin
		void'($urandom(32'h6830));
		reset        = 1'b1;
		left         = 1'b0;
		right        = 1'b0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;

		start_test("reset");
		reset_dut();
		end_test();

		start_test("win");
		play(0, dodge_pkg::SURVIVE_STEPS + 4);
		assert (m_state == dodge_pkg::WON)
		else
		begin
			$display("win game did not reach the win picture");
			errors++;
		end
		end_test();

		start_test("mid_reset");
		play(1, 5);
		wait_cycle(6 * STEP + 5);
		reset_dut();
		end_test();

		start_test("lose");
		play(1, dodge_pkg::SURVIVE_STEPS + 4);
		assert (m_state == dodge_pkg::LOST)
		else
		begin
			$display("chase game ended without losing all life");
			errors++;
		end
		end_test();

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG) @(posedge CLK);
		$display("watchdog expired during test %s before the run finished", test_name);
		$display("Verification failed");
		$finish;
	end

endmodule

// ==== project.f ====
rtl/dodge_pkg.sv
rtl/frame_write_if.sv
rtl/scan_read_if.sv
rtl/tick_divider.sv
rtl/obstacle_field.sv
rtl/game_status.sv
rtl/frame_store.sv
rtl/matrix_scan.sv
rtl/dodge_top.sv
tb/tb_dodge.sv

// ==== run.sh ====
#!/bin/bash
# build and run the dodge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_dodge -f project.f -Mdir obj_dir \
	> build.log 2>&1 \
	&& ./obj_dir/Vtb_dodge > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Verification failed" sim.log && exit 1 || exit 0
